// File: build.f
+incdir+logic
logic/fm_reg_pkg.sv
logic/fm_addr_decode.sv
logic/fm_slot_ctrl.sv
logic/fm_op_regs.sv
logic/fm_ch_regs.sv
logic/fm_keyon.sv
logic/fm_reg_top.sv
testbench/fm_reg_tb.sv

// File: logic/fm_addr_decode.sv
// -------------------------------------------------
// Purely combinational
// Unknown addresses give no request
// Channel and key-on requests target the M1 slot
// -------------------------------------------------
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_addr_decode (
    input  logic                 wr,
    input  logic [7:0]           addr,
    input  logic [7:0]           din,
    output fm_reg_pkg::upd_req_t req,
    output logic                 req_valid
);

    always_comb begin
        req.kind     = fm_reg_pkg::NONE;
        req.slot     = 5'd0;
        req.data.raw = din;
        if (addr == `FM_ADDR_KON) begin
            req.kind = fm_reg_pkg::KON;
            req.slot = {2'b00, din[2:0]};       // M1 slot of the channel
        end else if (addr >= `FM_ADDR_CH_BASE && addr < `FM_ADDR_OP_BASE) begin
            req.slot = {2'b00, addr[2:0]};
            case (addr[4:3])
                2'd0:    req.kind = fm_reg_pkg::RL_FB_CON;
                2'd1:    req.kind = fm_reg_pkg::KC;
                2'd2:    req.kind = fm_reg_pkg::KF;
                default: req.kind = fm_reg_pkg::PMS_AMS;
            endcase
        end else if (addr >= `FM_ADDR_OP_BASE) begin
            req.slot = addr[4:0];               // Op in [4:3], channel in [2:0]
            case (addr[7:5])
                3'd2:    req.kind = fm_reg_pkg::DT1_MUL;
                3'd3:    req.kind = fm_reg_pkg::TL;
                3'd4:    req.kind = fm_reg_pkg::KS_AR;
                3'd5:    req.kind = fm_reg_pkg::AMS_D1R;
                3'd6:    req.kind = fm_reg_pkg::DT2_D2R;
                3'd7:    req.kind = fm_reg_pkg::D1L_RR;
                default: req.kind = fm_reg_pkg::NONE;
            endcase
        end
    end

    assign req_valid = wr && (req.kind != fm_reg_pkg::NONE);

endmodule

// File: logic/fm_ch_regs.sv
// -------------------------------------------------
// Channel writes land while the counter is on M1
// Carrier flag follows the CON algorithm table
// -------------------------------------------------
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_ch_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [4:0]             cur_slot,
    input  logic                   apply,
    input  fm_reg_pkg::upd_req_t   apply_req,
    output fm_reg_pkg::ch_params_t ch_out,
    output logic                   carrier_out
);

    fm_reg_pkg::ch_params_t mem [`FM_N_CH];
    fm_reg_pkg::ch_params_t next_entry;
    fm_reg_pkg::reg_data_u  d;
    logic                   carrier;

    // op is 0 M1, 1 M2, 2 C1, 3 C2
    function automatic logic is_carrier(input logic [2:0] con, input logic [1:0] op);
        logic c;
        case (con)
            3'd4:       c = (op >= 2'd2);
            3'd5, 3'd6: c = (op >= 2'd1);
            3'd7:       c = 1'b1;
            default:    c = (op == 2'd3);   // Serial chains end on C2
        endcase
        return c;
    endfunction

    assign d = apply_req.data;

    always_comb begin
        next_entry = mem[cur_slot[2:0]];
        if (apply) begin
            case (apply_req.kind)
                fm_reg_pkg::RL_FB_CON: begin
                    next_entry.rl  = d.ch_view.hi2;
                    next_entry.fb  = d.ch_view.mid3;
                    next_entry.con = d.ch_view.lo3;
                end
                fm_reg_pkg::KC: begin
                    next_entry.kc = d.raw[6:0];
                end
                fm_reg_pkg::KF: begin
                    next_entry.kf = d.raw[7:2];
                end
                fm_reg_pkg::PMS_AMS: begin
                    next_entry.pms = d.raw[6:4];
                    next_entry.ams = d.raw[1:0];
                end
                default: begin
                    next_entry = mem[cur_slot[2:0]];    // Operator and key-on kinds
                end
            endcase
        end
    end

    assign carrier = is_carrier(next_entry.con, cur_slot[4:3]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FM_N_CH; i++) begin
                mem[i] <= '0;
            end
            ch_out      <= '0;
            carrier_out <= 1'b0;
        end else begin
            mem[cur_slot[2:0]] <= next_entry;
            ch_out             <= next_entry;
            carrier_out        <= carrier;
        end
    end

    // Decoder targets M1 and the controller applies on that slot
    a_ch_on_m1: assert property (
        @(posedge clk) disable iff (rst)
        apply && apply_req.kind inside {fm_reg_pkg::RL_FB_CON, fm_reg_pkg::KC,
                                        fm_reg_pkg::KF, fm_reg_pkg::PMS_AMS}
            |-> cur_slot[4:3] == 2'd0
    ) else $error("channel write applied off the M1 slot");

endmodule

// File: logic/fm_keyon.sv
// -------------------------------------------------
// One key-on write sets all four operators of a channel
// No CSM key-on from timer overflow
// -------------------------------------------------
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_keyon (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           cur_slot,
    input  logic                 apply,
    input  fm_reg_pkg::upd_req_t apply_req,
    output logic                 keyon_out
);

    logic [`FM_N_SLOT-1:0] kon;
    logic [`FM_N_SLOT-1:0] kon_next;

    always_comb begin
        kon_next = kon;
        if (apply && apply_req.kind == fm_reg_pkg::KON) begin
            for (int k = 0; k < 4; k++) begin
                kon_next[k * `FM_N_CH + apply_req.data.kon_view.ch] =
                    apply_req.data.kon_view.op_mask[k];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kon       <= '0;
            keyon_out <= 1'b0;
        end else begin
            kon       <= kon_next;
            keyon_out <= kon_next[cur_slot];    // M1 bit shows at once
        end
    end

    // Key-on requests carry the channel in both slot and data
    a_kon_slot: assert property (
        @(posedge clk) disable iff (rst)
        apply && apply_req.kind == fm_reg_pkg::KON
            |-> cur_slot == {2'b00, apply_req.data.kon_view.ch}
    ) else $error("key-on applied away from the channel's M1 slot");

endmodule

// File: logic/fm_op_regs.sv
// -------------------------------------------------
// Read-modify-write on the slot being played
// A write shows on the stream in the cycle busy falls
// -------------------------------------------------
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_op_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [4:0]             cur_slot,
    input  logic                   apply,
    input  fm_reg_pkg::upd_req_t   apply_req,
    output fm_reg_pkg::op_params_t op_out
);

    fm_reg_pkg::op_params_t mem [`FM_N_SLOT];
    fm_reg_pkg::op_params_t next_entry;
    fm_reg_pkg::reg_data_u  d;

    assign d = apply_req.data;

    // Apply only fires when cur_slot is the target, so the entry read is the one to change
    always_comb begin
        next_entry = mem[cur_slot];
        if (apply) begin
            case (apply_req.kind)
                fm_reg_pkg::DT1_MUL: begin
                    next_entry.dt1 = d.op_view.hi4[2:0];    // Bit 7 unused
                    next_entry.mul = d.op_view.lo4;
                end
                fm_reg_pkg::TL: begin
                    next_entry.tl = d.raw[6:0];
                end
                fm_reg_pkg::KS_AR: begin
                    next_entry.ks = d.raw[7:6];
                    next_entry.ar = d.raw[4:0];
                end
                fm_reg_pkg::AMS_D1R: begin
                    next_entry.amsen = d.raw[7];
                    next_entry.d1r   = d.raw[4:0];
                end
                fm_reg_pkg::DT2_D2R: begin
                    next_entry.dt2 = d.raw[7:6];
                    next_entry.d2r = d.raw[4:0];
                end
                fm_reg_pkg::D1L_RR: begin
                    next_entry.d1l = d.op_view.hi4;
                    next_entry.rr  = d.op_view.lo4;
                end
                default: begin
                    next_entry = mem[cur_slot];     // Channel and key-on kinds
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FM_N_SLOT; i++) begin
                mem[i] <= '0;
            end
            op_out <= '0;
        end else begin
            mem[cur_slot] <= next_entry;
            op_out        <= next_entry;
        end
    end

endmodule

// File: logic/fm_reg_pkg.sv
// -------------------------------------------------
// Shared types of the register section
// Slot order is op*8 + ch with M1=0, M2=1, C1=2, C2=3
// -------------------------------------------------
package fm_reg_pkg;

    typedef enum logic [3:0] {
        NONE      = 4'd0,
        KON       = 4'd1,
        RL_FB_CON = 4'd2,
        KC        = 4'd3,
        KF        = 4'd4,
        PMS_AMS   = 4'd5,
        DT1_MUL   = 4'd6,
        TL        = 4'd7,
        KS_AR     = 4'd8,
        AMS_D1R   = 4'd9,
        DT2_D2R   = 4'd10,
        D1L_RR    = 4'd11
    } reg_kind_e;

    typedef struct packed {
        logic       pad;
        logic [3:0] op_mask;    // Bit k drives operator k
        logic [2:0] ch;
    } kon_view_t;

    typedef struct packed {
        logic [1:0] hi2;        // RL
        logic [2:0] mid3;       // FB
        logic [2:0] lo3;        // CON
    } ch_view_t;

    typedef struct packed {
        logic [3:0] hi4;
        logic [3:0] lo4;
    } op_view_t;

    typedef union packed {
        logic [7:0] raw;
        kon_view_t  kon_view;
        ch_view_t   ch_view;
        op_view_t   op_view;
    } reg_data_u;

    typedef struct packed {
        reg_kind_e  kind;
        logic [4:0] slot;
        reg_data_u  data;
    } upd_req_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amsen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
    } op_params_t;

    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fb;
        logic [2:0] con;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_params_t;

endpackage

// File: logic/fm_reg_settings.svh
// -------------------------------------------------
// Sizes are fixed by the register map
// Base addresses follow the FM chip layout
// -------------------------------------------------
`ifndef FM_REG_SETTINGS_SVH
`define FM_REG_SETTINGS_SVH

`define FM_N_SLOT       32      // Operator slots per sample
`define FM_N_CH         8       // Channels
`define FM_ADDR_KON     8'h08   // Key-on register
`define FM_ADDR_CH_BASE 8'h20   // First channel register
`define FM_ADDR_OP_BASE 8'h40   // First operator register

`endif

// File: logic/fm_reg_top.sv
// -------------------------------------------------
// Host writes use a plain strobe, dropped while busy
// All stream fields belong to slot_out
// -------------------------------------------------
`timescale 1ns/1ps

module fm_reg_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr,
    input  logic [7:0]             addr,
    input  logic [7:0]             din,
    output logic                   busy,
    output logic [4:0]             slot_out,
    output fm_reg_pkg::op_params_t op_out,
    output fm_reg_pkg::ch_params_t ch_out,
    output logic                   keyon_out,
    output logic                   carrier_out
);

    fm_reg_pkg::upd_req_t req;
    fm_reg_pkg::upd_req_t apply_req;
    logic                 req_valid;
    logic                 apply;
    logic [4:0]           cur_slot;

    fm_addr_decode i_decode (
        .wr        (wr),
        .addr      (addr),
        .din       (din),
        .req       (req),
        .req_valid (req_valid)
    );

    fm_slot_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .busy      (busy),
        .cur_slot  (cur_slot),
        .slot_out  (slot_out),
        .apply     (apply),
        .apply_req (apply_req)
    );

    fm_op_regs i_op_regs (
        .clk       (clk),
        .rst       (rst),
        .cur_slot  (cur_slot),
        .apply     (apply),
        .apply_req (apply_req),
        .op_out    (op_out)
    );

    fm_ch_regs i_ch_regs (
        .clk         (clk),
        .rst         (rst),
        .cur_slot    (cur_slot),
        .apply       (apply),
        .apply_req   (apply_req),
        .ch_out      (ch_out),
        .carrier_out (carrier_out)
    );

    fm_keyon i_keyon (
        .clk       (clk),
        .rst       (rst),
        .cur_slot  (cur_slot),
        .apply     (apply),
        .apply_req (apply_req),
        .keyon_out (keyon_out)
    );

endmodule

// File: logic/fm_slot_ctrl.sv
// -------------------------------------------------
// One pending write at a time
// New writes are dropped while busy
// Apply fires 1 to 32 cycles after the write strobe
// -------------------------------------------------
`timescale 1ns/1ps

module fm_slot_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  fm_reg_pkg::upd_req_t req,
    input  logic                 req_valid,
    output logic                 busy,
    output logic [4:0]           cur_slot,
    output logic [4:0]           slot_out,
    output logic                 apply,
    output fm_reg_pkg::upd_req_t apply_req
);

    fm_reg_pkg::upd_req_t pend_req;
    logic                 accept;

    assign accept = req_valid && !busy;

    // Stores read cur_slot and register once, so slot_out trails it by one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_slot <= 5'd1;                   // Stream leads with slot 0
            slot_out <= 5'd0;
        end else begin
            cur_slot <= cur_slot + 5'd1;        // Wraps 31 to 0
            slot_out <= cur_slot;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (apply) begin
            busy <= 1'b0;                       // Write done
        end else if (accept) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_req <= req;
        end
    end

    assign apply     = busy && (cur_slot == pend_req.slot);
    assign apply_req = pend_req;

    // Only decoded register kinds may be held and applied
    a_apply_kind: assert property (
        @(posedge clk) disable iff (rst)
        apply |-> apply_req.kind != fm_reg_pkg::NONE
    ) else $error("apply of a request with no register kind");

    a_busy_fall: assert property (
        @(posedge clk) disable iff (rst)
        apply |=> !busy
    ) else $error("busy held after apply");

    // The counter visits every slot within one round
    a_apply_bound: assert property (
        @(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[0:31] apply
    ) else $error("pending write never applied");

endmodule

// File: testbench/fm_reg_tb.sv
// -------------------------------------------------
// Shadow model is updated when busy falls and is checked
// at the falling clock edge against the whole slot stream
// -------------------------------------------------
`timescale 1ns/1ps
`include "fm_reg_settings.svh"

module fm_reg_tb;

    localparam int N_WRITES    = 60 + 32 + 16 + 8 + 16 + 4;    // All writes over all tests
    localparam int CYCLE_LIMIT = N_WRITES * 40 + 500;

    logic                   clk;
    logic                   rst;
    logic                   wr;
    logic [7:0]             addr;
    logic [7:0]             din;
    logic                   busy;
    logic [4:0]             slot_out;
    fm_reg_pkg::op_params_t op_out;
    fm_reg_pkg::ch_params_t ch_out;
    logic                   keyon_out;
    logic                   carrier_out;

    fm_reg_pkg::op_params_t sh_op [`FM_N_SLOT];
    fm_reg_pkg::ch_params_t sh_ch [`FM_N_CH];
    logic [`FM_N_SLOT-1:0]  sh_kon;
    logic [4:0]             exp_slot;
    string                  test_name;
    int                     cycles;

    fm_reg_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .addr        (addr),
        .din         (din),
        .busy        (busy),
        .slot_out    (slot_out),
        .op_out      (op_out),
        .ch_out      (ch_out),
        .keyon_out   (keyon_out),
        .carrier_out (carrier_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Register map applied to the shadow, unknown addresses ignored
    function automatic void ref_apply(input logic [7:0] a, input logic [7:0] v);
        logic [2:0] ch;
        logic [4:0] s;
        ch = a[2:0];
        s  = a[4:0];
        if (a == `FM_ADDR_KON) begin
            for (int k = 0; k < 4; k++) begin
                sh_kon[k * `FM_N_CH + v[2:0]] = v[3 + k];
            end
        end else if (a >= `FM_ADDR_CH_BASE && a < `FM_ADDR_OP_BASE) begin
            case (a[4:3])
                2'd0: begin
                    sh_ch[ch].rl  = v[7:6];
                    sh_ch[ch].fb  = v[5:3];
                    sh_ch[ch].con = v[2:0];
                end
                2'd1: sh_ch[ch].kc = v[6:0];
                2'd2: sh_ch[ch].kf = v[7:2];
                default: begin
                    sh_ch[ch].pms = v[6:4];
                    sh_ch[ch].ams = v[1:0];
                end
            endcase
        end else if (a >= `FM_ADDR_OP_BASE) begin
            case (a[7:5])
                3'd2: begin
                    sh_op[s].dt1 = v[6:4];
                    sh_op[s].mul = v[3:0];
                end
                3'd3: sh_op[s].tl = v[6:0];
                3'd4: begin
                    sh_op[s].ks = v[7:6];
                    sh_op[s].ar = v[4:0];
                end
                3'd5: begin
                    sh_op[s].amsen = v[7];
                    sh_op[s].d1r   = v[4:0];
                end
                3'd6: begin
                    sh_op[s].dt2 = v[7:6];
                    sh_op[s].d2r = v[4:0];
                end
                default: begin
                    sh_op[s].d1l = v[7:4];
                    sh_op[s].rr  = v[3:0];
                end
            endcase
        end
    endfunction

    // Carrier set per algorithm, bit k is operator k
    function automatic logic ref_carrier(input logic [2:0] con, input logic [1:0] op);
        logic [3:0] mask;
        if (con <= 3'd3) begin
            mask = 4'b1000;
        end else if (con == 3'd4) begin
            mask = 4'b1100;
        end else if (con == 3'd7) begin
            mask = 4'b1111;
        end else begin
            mask = 4'b1110;
        end
        return mask[op];
    endfunction

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("Finished with errors");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 33) begin
                $display("busy stayed high for more than 33 cycles after a write");
                $display("Finished with errors");
                $fatal(1, "write never completed");
            end
        end
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] v, input bit mapped);
        @(posedge clk);
        #1;
        wr   = 1'b1;
        addr = a;
        din  = v;
        @(posedge clk);
        #1;
        wr = 1'b0;
        check("busy after wr", mapped, busy);
        wait_not_busy();
        ref_apply(a, v);
    endtask

    // Second strobe lands while the first write is pending
    task automatic write_during_busy(input logic [7:0] a, input logic [7:0] v,
                                     input logic [7:0] a2, input logic [7:0] v2);
        @(posedge clk);
        #1;
        wr   = 1'b1;
        addr = a;
        din  = v;
        @(posedge clk);
        #1;
        check("busy before second wr", 1, busy);
        addr = a2;
        din  = v2;
        @(posedge clk);
        #1;
        wr = 1'b0;
        wait_not_busy();
        ref_apply(a, v);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // Whole stream compared once per slot
    always @(negedge clk) begin
        if (!rst) begin
            check("slot_out", exp_slot, slot_out);
            check("op_out", sh_op[slot_out], op_out);
            check("ch_out", sh_ch[slot_out[2:0]], ch_out);
            check("keyon_out", sh_kon[slot_out], keyon_out);
            check("carrier_out", ref_carrier(sh_ch[slot_out[2:0]].con, slot_out[4:3]),
                  carrier_out);
            exp_slot = exp_slot + 5'd1;
        end
    end

    initial begin
        rst       = 1'b1;
        wr        = 1'b0;
        addr      = 8'h00;
        din       = 8'h00;
        exp_slot  = 5'd0;
        cycles    = 0;
        sh_kon    = '0;
        test_name = "reset";
        void'($urandom(95));
        for (int i = 0; i < `FM_N_SLOT; i++) begin
            sh_op[i] = '0;
        end
        for (int i = 0; i < `FM_N_CH; i++) begin
            sh_ch[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 64; i++) begin
            check("busy idle", 0, busy);
            @(posedge clk);
            #1;
        end

        test_name = "op_writes";
        for (int i = 0; i < 60; i++) begin
            write_reg(`FM_ADDR_OP_BASE + 8'($urandom % 192), 8'($urandom), 1'b1);
        end
        idle(32);

        test_name = "ch_writes";
        for (int ch = 0; ch < `FM_N_CH; ch++) begin
            for (int r = 0; r < 4; r++) begin
                write_reg(`FM_ADDR_CH_BASE + 8'(r * 8 + ch), 8'($urandom), 1'b1);
            end
        end
        idle(32);

        test_name = "keyon";
        for (int i = 0; i < 16; i++) begin
            write_reg(`FM_ADDR_KON, 8'($urandom), 1'b1);
        end
        idle(32);

        test_name = "carrier";
        for (int con = 0; con < 8; con++) begin
            write_reg(`FM_ADDR_CH_BASE + 8'(con), {2'($urandom), 3'($urandom), 3'(con)}, 1'b1);
        end
        idle(32);

        test_name = "busy_drop";
        for (int i = 0; i < 8; i++) begin
            write_during_busy(`FM_ADDR_OP_BASE + 8'($urandom % 192), 8'($urandom),
                              `FM_ADDR_OP_BASE + 8'($urandom % 192), 8'($urandom));
        end
        write_reg(8'h00, 8'($urandom), 1'b0);
        write_reg(8'h09, 8'($urandom), 1'b0);
        write_reg(8'h10, 8'($urandom), 1'b0);
        write_reg(8'h1F, 8'($urandom), 1'b0);
        idle(32);

        $display("Finished with no errors");
        $finish;
    end

endmodule
